// File: project.f
source/buffer_pkg.sv
source/flow_pkg.sv
source/ram_1r1w.sv
source/small_fifo.sv
source/release_intake.sv
source/buffer_release.sv
source/free_ptr_list.sv
source/buffer_manager_top.sv
test/buffer_manager_properties.sv
test/buffer_manager_tb.sv

// File: test/buffer_manager_tb.sv
`timescale 1ns/100ps

module buffer_manager_tb;

    localparam int RAND_CYCLES  = 1500;
    localparam int LONG_CYCLES  = 3000;
    localparam int DRAIN_BUDGET = 1000;
    // reset and sweep, two collections, zero counts, back to back, two random runs
    localparam int LIMIT = 100 + 2 * 400 + 400 + 400 + RAND_CYCLES + LONG_CYCLES
                         + 4 * DRAIN_BUDGET + 200;

    logic                   clk;
    logic                   reset;
    logic                   ptr_credit;
    logic                   count_valid;
    flow_pkg::count_write_t count_wr;
    logic                   rel_valid;
    flow_pkg::release_t     rel;
    logic                   ptr_valid;
    buffer_pkg::buf_ptr_t   ptr;
    logic                   rel_credit;

    // model of the enqueue agent and the reading ports
    logic [buffer_pkg::NUM_BUFS-1:0] held;
    logic [buffer_pkg::NUM_BUFS-1:0] seen;
    int          remaining [buffer_pkg::NUM_BUFS];
    int          pend [$];
    int          held_cnt, ptr_out, rel_cr, rel_sent, credit_seen;
    int          issued, errors, tests, grant_left, force_count, last_rel;
    logic        rel_on, b2b;
    logic [31:0] lfsr;
    int          cycles = 0;

    buffer_manager_top u_buffer_manager_top (
        .clk         (clk),
        .reset       (reset),
        .ptr_credit  (ptr_credit),
        .count_valid (count_valid),
        .count_wr    (count_wr),
        .rel_valid   (rel_valid),
        .rel         (rel),
        .ptr_valid   (ptr_valid),
        .ptr         (ptr),
        .rel_credit  (rel_credit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // fibonacci LFSR with taps 32 22 2 1, stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic log_failure(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s finished at %0t, errors so far %0d", name, $time, errors);
    endtask

    // one cycle: read the DUT outputs, update the model, then drive new inputs
    task automatic step();
        int p;
        int c;
        int n;
        @(posedge clk);
        #2;
        ptr_credit  = 1'b0;
        count_valid = 1'b0;
        rel_valid   = 1'b0;
        if (ptr_valid) begin
            if (ptr_out == 0) begin
                log_failure($sformatf("pointer %0d issued without a credit", ptr));
            end
            if (held[ptr]) begin
                log_failure($sformatf("pointer %0d issued while the agent holds it", ptr));
            end
            held[ptr] = 1'b1;
            seen[ptr] = 1'b1;
            held_cnt++;
            ptr_out--;
            issued++;
            pend.push_back(int'(ptr));
        end
        // the copy count follows the issue of its pointer
        if (pend.size() != 0) begin
            p = pend.pop_front();
            c = (force_count >= 0) ? force_count : rand_bits(3);
            count_valid    = 1'b1;
            count_wr.ptr   = buffer_pkg::buf_ptr_t'(p);
            count_wr.port  = buffer_pkg::port_id_t'(rand_bits(3));
            count_wr.count = buffer_pkg::copy_count_t'(c);
            remaining[p]   = c;
            if (c == 0) begin
                held[p] = 1'b0;
                held_cnt--;
            end
        end
        // a credit seen in this cycle is only spent from the next cycle on
        if (rel_on && rel_cr > 0 && (b2b || rand_bits(2) != 0)) begin
            p = b2b ? last_rel : rand_bits(6);
            n = 0;
            while (remaining[p] == 0 && n < buffer_pkg::NUM_BUFS) begin
                p = (p + 1) % buffer_pkg::NUM_BUFS;
                n++;
            end
            if (remaining[p] != 0) begin
                rel_valid = 1'b1;
                rel.ptr   = buffer_pkg::buf_ptr_t'(p);
                rel.port  = buffer_pkg::port_id_t'(rand_bits(3));
                remaining[p]--;
                last_rel = p;
                rel_cr--;
                rel_sent++;
                if (remaining[p] == 0) begin
                    held[p] = 1'b0;
                    held_cnt--;
                end
            end
        end
        if (grant_left > 0 && ptr_out < flow_pkg::PTR_CREDIT_MAX && rand_bits(1) != 0) begin
            ptr_credit = 1'b1;
            grant_left--;
            ptr_out++;
        end
        if (rel_credit) begin
            rel_cr++;
            credit_seen++;
        end
        if (rel_cr > flow_pkg::REL_CREDITS) begin
            log_failure("more release credits returned than releases sent");
        end
    endtask

    // release everything still held and check the credits once idle
    task automatic drain(input string name);
        int wait_cycles;
        grant_left = 0;
        while (held_cnt != 0 || ptr_out != 0 || pend.size() != 0) begin
            step();
        end
        // queued releases come back as credits once the intake pops them
        wait_cycles = 0;
        while (rel_cr != flow_pkg::REL_CREDITS && wait_cycles < 4 * flow_pkg::REL_CREDITS) begin
            step();
            wait_cycles++;
        end
        if (rel_cr != flow_pkg::REL_CREDITS) begin
            log_failure($sformatf("release credits at %0d when idle", rel_cr));
        end
        if (credit_seen != rel_sent) begin
            log_failure($sformatf("%0d credit pulses for %0d releases", credit_seen, rel_sent));
        end
        finish_test(name);
    endtask

    task automatic collect_all(input string name);
        int start;
        start       = issued;
        seen        = '0;
        force_count = 1;
        rel_on      = 1'b0;
        grant_left  = buffer_pkg::NUM_BUFS;
        while (issued - start < buffer_pkg::NUM_BUFS) begin
            step();
        end
        if (seen != '1) begin
            log_failure("the issued pointers do not cover every buffer");
        end
        finish_test(name);
    endtask

    initial begin
        int start;
        reset       = 1'b1;
        ptr_credit  = 1'b0;
        count_valid = 1'b0;
        count_wr    = '0;
        rel_valid   = 1'b0;
        rel         = '0;
        lfsr        = 32'h73f2;
        held        = '0;
        seen        = '0;
        held_cnt    = 0;
        ptr_out     = 0;
        rel_cr      = flow_pkg::REL_CREDITS;
        rel_sent    = 0;
        credit_seen = 0;
        issued      = 0;
        errors      = 0;
        tests       = 0;
        grant_left  = 0;
        force_count = -1;
        last_rel    = 0;
        rel_on      = 1'b0;
        b2b         = 1'b0;
        foreach (remaining[i]) begin
            remaining[i] = 0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        collect_all("issue_all");
        rel_on      = 1'b1;
        force_count = -1;
        grant_left  = 1000000;
        repeat (RAND_CYCLES) step();
        drain("random_release");

        // more zero-count issues than buffers, so every one must come back
        force_count = 0;
        start       = issued;
        grant_left  = 80;
        while (issued - start < 80) begin
            step();
        end
        force_count = -1;
        drain("zero_count");

        b2b         = 1'b1;
        force_count = 6;
        grant_left  = 24;
        while (grant_left > 0) begin
            step();
        end
        drain("back_to_back");
        b2b         = 1'b0;
        force_count = -1;

        grant_left = 1000000;
        repeat (LONG_CYCLES) step();
        drain("long_random");
        collect_all("final_issue");

        $display("summary: %0d tests, %0d pointers issued, %0d releases, %0d errors",
                 tests, issued, rel_sent, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: test/buffer_manager_properties.sv
`timescale 1ns/100ps

module buffer_manager_properties (
    input logic clk,
    input logic reset,
    input logic req,
    input logic fwd_valid,
    input logic drop_busy,
    input logic freed_valid
);

    // a freed pointer leaves the counting block five cycles after its request
    freed_after_request: assert property (@(posedge clk) disable iff (reset)
        freed_valid |-> $past(req, 5))
        else $error("freed_valid without a request five cycles earlier");

    drop_idle_after_reset: assert property (@(posedge clk)
        reset |=> !drop_busy)
        else $error("drop_busy high right after reset");

    // the intake has to yield while a zero-count drop waits
    no_release_during_drop: assert property (@(posedge clk) disable iff (reset)
        drop_busy |-> !fwd_valid)
        else $error("release forwarded while the drop queue was busy");

endmodule

bind buffer_release buffer_manager_properties u_buffer_manager_properties (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .fwd_valid   (fwd_valid),
    .drop_busy   (drop_busy),
    .freed_valid (freed_valid)
);

// File: source/buffer_manager_top.sv
`timescale 1ns/100ps

module buffer_manager_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ptr_credit,
    input  logic                   count_valid,
    input  flow_pkg::count_write_t count_wr,
    input  logic                   rel_valid,
    input  flow_pkg::release_t     rel,
    output logic                   ptr_valid,
    output buffer_pkg::buf_ptr_t   ptr,
    output logic                   rel_credit
);

    logic                 fwd_valid;
    flow_pkg::release_t   fwd;
    logic                 drop_busy;
    logic                 init_valid;
    buffer_pkg::buf_ptr_t init_ptr;
    logic                 freed_valid;
    buffer_pkg::buf_ptr_t freed_ptr;

    release_intake u_release_intake (
        .clk        (clk),
        .reset      (reset),
        .rel_valid  (rel_valid),
        .rel        (rel),
        .drop_busy  (drop_busy),
        .rel_credit (rel_credit),
        .fwd_valid  (fwd_valid),
        .fwd        (fwd)
    );

    buffer_release u_buffer_release (
        .clk         (clk),
        .reset       (reset),
        .init_valid  (init_valid),
        .init_ptr    (init_ptr),
        .count_valid (count_valid),
        .count_wr    (count_wr),
        .fwd_valid   (fwd_valid),
        .fwd         (fwd),
        .drop_busy   (drop_busy),
        .freed_valid (freed_valid),
        .freed_ptr   (freed_ptr)
    );

    free_ptr_list u_free_ptr_list (
        .clk         (clk),
        .reset       (reset),
        .ptr_credit  (ptr_credit),
        .freed_valid (freed_valid),
        .freed_ptr   (freed_ptr),
        .init_valid  (init_valid),
        .init_ptr    (init_ptr),
        .ptr_valid   (ptr_valid),
        .ptr         (ptr)
    );

endmodule

// File: source/free_ptr_list.sv
`timescale 1ns/100ps

module free_ptr_list (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ptr_credit,
    input  logic                 freed_valid,
    input  buffer_pkg::buf_ptr_t freed_ptr,
    output logic                 init_valid,
    output buffer_pkg::buf_ptr_t init_ptr,
    output logic                 ptr_valid,
    output buffer_pkg::buf_ptr_t ptr
);

    flow_pkg::free_state_t state;
    buffer_pkg::buf_ptr_t  sweep_ptr;
    logic [$clog2(flow_pkg::PTR_CREDIT_MAX + 1)-1:0] credits;

    logic                 fifo_push;
    buffer_pkg::buf_ptr_t fifo_din;
    buffer_pkg::buf_ptr_t fifo_dout;
    logic                 fifo_empty;
    logic                 issue;

    // after reset every pointer is walked once, filling the list and
    // clearing the matching release counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= flow_pkg::INIT_SWEEP;
            sweep_ptr  <= '0;
            init_valid <= 1'b0;
        end else begin
            init_valid <= (state == flow_pkg::INIT_SWEEP);
            if (state == flow_pkg::INIT_SWEEP) begin
                sweep_ptr <= sweep_ptr + 1'b1;
                if (sweep_ptr == buffer_pkg::buf_ptr_t'(buffer_pkg::NUM_BUFS - 1)) begin
                    state <= flow_pkg::RUNNING;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        init_ptr <= sweep_ptr;
    end

    // never more than NUM_BUFS pointers exist, so the list cannot overflow
    assign fifo_push = init_valid || freed_valid;
    assign fifo_din  = init_valid ? init_ptr : freed_ptr;

    small_fifo #(
        .WIDTH (buffer_pkg::BUF_PTR_BITS),
        .DEPTH (buffer_pkg::NUM_BUFS)
    ) u_free_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (fifo_push),
        .pop   (issue),
        .din   (fifo_din),
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  ()
    );

    assign issue = (state == flow_pkg::RUNNING) && (credits != '0) && !fifo_empty;

    // a credit arriving with a full counter is lost unless one is spent too
    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= '0;
            ptr_valid <= 1'b0;
        end else begin
            ptr_valid <= issue;
            if (ptr_credit && !issue && credits != flow_pkg::PTR_CREDIT_MAX) begin
                credits <= credits + 1'b1;
            end else if (!ptr_credit && issue) begin
                credits <= credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        ptr <= fifo_dout;
    end

endmodule

// File: source/buffer_release.sv
`timescale 1ns/100ps

module buffer_release (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   init_valid,
    input  buffer_pkg::buf_ptr_t   init_ptr,
    input  logic                   count_valid,
    input  flow_pkg::count_write_t count_wr,
    input  logic                   fwd_valid,
    input  flow_pkg::release_t     fwd,
    output logic                   drop_busy,
    output logic                   freed_valid,
    output buffer_pkg::buf_ptr_t   freed_ptr
);

    // count write after its input register
    logic                    cw_valid;
    flow_pkg::count_write_t  cw;
    buffer_pkg::copy_count_t cw_stored;

    // zero-count drops waiting for a free slot in the pipeline
    flow_pkg::release_t drop_in;
    flow_pkg::release_t drop_head;
    logic               drop_empty;
    logic               drop_pop;

    // request pipeline, stage n holds a request n cycles after issue
    logic                 req;
    buffer_pkg::buf_ptr_t req_ptr;
    logic                 s1_valid, s2_valid, s3_valid, s4_valid;
    buffer_pkg::buf_ptr_t s1_ptr, s2_ptr, s3_ptr, s4_ptr;

    buffer_pkg::copy_count_t cnt_rdata, ctr_rdata;
    buffer_pkg::copy_count_t s3_cnt, s3_ctr;
    buffer_pkg::copy_count_t ctr_eff;
    logic                    s4_match;
    buffer_pkg::copy_count_t s4_ctr;
    buffer_pkg::copy_count_t ctr_base, ctr_next;

    // release counter write port and its two older copies for forwarding
    logic                    wr_p, ctr_wr, ctr_wr_d1, ctr_wr_d2;
    buffer_pkg::buf_ptr_t    waddr_p, ctr_waddr, ctr_waddr_d1, ctr_waddr_d2;
    buffer_pkg::copy_count_t wdata_p, ctr_wdata, ctr_wdata_d1, ctr_wdata_d2;

    // the count store keeps count minus one so the compare needs no adder
    always_ff @(posedge clk) begin
        cw        <= count_wr;
        cw_stored <= (count_wr.count == '0) ? '0 : count_wr.count - 1'b1;
    end

    always_comb begin
        drop_in.ptr  = cw.ptr;
        drop_in.port = cw.port;
    end

    small_fifo #(
        .WIDTH ($bits(flow_pkg::release_t)),
        .DEPTH (2)
    ) u_drop_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (cw_valid && cw.count == '0),
        .pop   (drop_pop),
        .din   (drop_in),
        .dout  (drop_head),
        .empty (drop_empty),
        .full  ()
    );

    assign drop_busy = !drop_empty;
    assign drop_pop  = !drop_empty && !fwd_valid;
    assign req       = fwd_valid || drop_pop;
    assign req_ptr   = fwd_valid ? fwd.ptr : drop_head.ptr;

    ram_1r1w #(
        .WIDTH      (buffer_pkg::COUNT_BITS),
        .DEPTH_BITS (buffer_pkg::BUF_PTR_BITS)
    ) u_count_store (
        .clk   (clk),
        .wr    (cw_valid),
        .waddr (cw.ptr),
        .din   (cw_stored),
        .raddr (s1_ptr),
        .dout  (cnt_rdata)
    );

    ram_1r1w #(
        .WIDTH      (buffer_pkg::COUNT_BITS),
        .DEPTH_BITS (buffer_pkg::BUF_PTR_BITS)
    ) u_release_ctr (
        .clk   (clk),
        .wr    (ctr_wr),
        .waddr (ctr_waddr),
        .din   (ctr_wdata),
        .raddr (s1_ptr),
        .dout  (ctr_rdata)
    );

    // the memory read misses counter writes from up to four requests ahead.
    // take the newest matching write, which may be the one forming right now
    always_comb begin
        if (wr_p && waddr_p == s3_ptr) begin
            ctr_eff = wdata_p;
        end else if (ctr_wr && ctr_waddr == s3_ptr) begin
            ctr_eff = ctr_wdata;
        end else if (ctr_wr_d1 && ctr_waddr_d1 == s3_ptr) begin
            ctr_eff = ctr_wdata_d1;
        end else if (ctr_wr_d2 && ctr_waddr_d2 == s3_ptr) begin
            ctr_eff = ctr_wdata_d2;
        end else begin
            ctr_eff = s3_ctr;
        end
    end

    // on the last copy the all-ones marker wraps to zero for the next use
    assign ctr_base = s4_match ? '1 : s4_ctr;
    assign ctr_next = ctr_base + 1'b1;

    // init sweep clears counters, it never overlaps release traffic
    assign wr_p    = s4_valid || init_valid;
    assign waddr_p = init_valid ? init_ptr : s4_ptr;
    assign wdata_p = init_valid ? '0 : ctr_next;

    always_ff @(posedge clk) begin
        s1_ptr       <= req_ptr;
        s2_ptr       <= s1_ptr;
        s3_ptr       <= s2_ptr;
        s4_ptr       <= s3_ptr;
        s3_cnt       <= cnt_rdata;
        s3_ctr       <= ctr_rdata;
        s4_match     <= (s3_cnt == ctr_eff);
        s4_ctr       <= ctr_eff;
        ctr_waddr    <= waddr_p;
        ctr_waddr_d1 <= ctr_waddr;
        ctr_waddr_d2 <= ctr_waddr_d1;
        ctr_wdata    <= wdata_p;
        ctr_wdata_d1 <= ctr_wdata;
        ctr_wdata_d2 <= ctr_wdata_d1;
        freed_ptr    <= s4_ptr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cw_valid    <= 1'b0;
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            s3_valid    <= 1'b0;
            s4_valid    <= 1'b0;
            ctr_wr      <= 1'b0;
            ctr_wr_d1   <= 1'b0;
            ctr_wr_d2   <= 1'b0;
            freed_valid <= 1'b0;
        end else begin
            cw_valid    <= count_valid;
            s1_valid    <= req;
            s2_valid    <= s1_valid;
            s3_valid    <= s2_valid;
            s4_valid    <= s3_valid;
            ctr_wr      <= wr_p;
            ctr_wr_d1   <= ctr_wr;
            ctr_wr_d2   <= ctr_wr_d1;
            freed_valid <= s4_valid && s4_match;
        end
    end

endmodule

// File: source/release_intake.sv
`timescale 1ns/100ps

module release_intake (
    input  logic               clk,
    input  logic               reset,
    input  logic               rel_valid,
    input  flow_pkg::release_t rel,
    input  logic               drop_busy,
    output logic               rel_credit,
    output logic               fwd_valid,
    output flow_pkg::release_t fwd
);

    flow_pkg::release_t head;
    logic               fifo_empty;
    logic               pop;

    // ports never send without a credit, so the queue cannot overflow.
    // after reset it is empty and the ports start from their own credit
    // counters
    small_fifo #(
        .WIDTH ($bits(flow_pkg::release_t)),
        .DEPTH (flow_pkg::REL_CREDITS)
    ) u_rel_fifo (
        .clk   (clk),
        .reset (reset),
        .push  (rel_valid),
        .pop   (pop),
        .din   (rel),
        .dout  (head),
        .empty (fifo_empty),
        .full  ()
    );

    // a pending zero-count drop owns the counting pipeline for this cycle
    assign pop = !fifo_empty && !drop_busy;

    // one release per cycle into the counting block
    assign fwd_valid = pop;
    assign fwd       = head;

    // each consumed release frees one slot, which goes back to the ports
    assign rel_credit = pop;

endmodule

// File: source/small_fifo.sv
`timescale 1ns/100ps

module small_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign empty   = (count == '0);
    assign full    = (count == DEPTH);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is visible without a read cycle
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/ram_1r1w.sv
`timescale 1ns/100ps

module ram_1r1w #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_BITS = 6
) (
    input  logic                  clk,
    input  logic                  wr,
    input  logic [DEPTH_BITS-1:0] waddr,
    input  logic [WIDTH-1:0]      din,
    input  logic [DEPTH_BITS-1:0] raddr,
    output logic [WIDTH-1:0]      dout
);

    logic [WIDTH-1:0] mem [2**DEPTH_BITS];

    // read and write land on the same edge, so a colliding read returns
    // the contents from before the write
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr];
    end

endmodule

// File: source/flow_pkg.sv
package flow_pkg;

    // copy count assignment from the enqueue agent
    typedef struct packed {
        buffer_pkg::buf_ptr_t    ptr;
        buffer_pkg::port_id_t    port;
        buffer_pkg::copy_count_t count;
    } count_write_t;

    // one copy released by a reading port.
    // the port id travels along but nothing checks it
    typedef struct packed {
        buffer_pkg::buf_ptr_t ptr;
        buffer_pkg::port_id_t port;
    } release_t;

    // release credits the ports hold after reset, also the intake FIFO depth
    localparam int REL_CREDITS = 4;

    // ceiling of the pointer credit counter in the free list
    localparam int PTR_CREDIT_MAX = 8;

    // free list runs one sweep over all pointers, then serves requests
    typedef enum logic {
        INIT_SWEEP,
        RUNNING
    } free_state_t;

endpackage

// File: source/buffer_pkg.sv
package buffer_pkg;

    // buffer pool size and the widths that follow from it
    localparam int BUF_PTR_BITS = 6;
    localparam int NUM_BUFS     = 2 ** BUF_PTR_BITS;

    // width of a reading port id
    localparam int PORT_ID_BITS = 3;

    // copy counts and release counters share one width
    localparam int COUNT_BITS   = 4;

    // pointer into the shared buffer pool
    typedef logic [BUF_PTR_BITS-1:0] buf_ptr_t;

    // output port that reads a buffer copy
    typedef logic [PORT_ID_BITS-1:0] port_id_t;

    // copy count or per-buffer release counter.
    // the all-ones value marks a buffer that was just freed, and the
    // increment that follows wraps it back to zero
    typedef logic [COUNT_BITS-1:0] copy_count_t;

endpackage
